/* common/bank_pkg.sv */
/*
 * Shared sizes for the banked scratchpad.
 * Host words are split into one 16-bit lane per bank.
 */

package bank_pkg;

  // Host port widths.
  localparam int ADDR_W = 16;
  localparam int DATA_W = 64;
  localparam int STRB_W = DATA_W / 8;

  // Number of host ports sharing the banks.
  localparam int NUM_PORTS = 2;

  // Bank geometry.
  localparam int NUM_BANKS   = 4;
  localparam int BANK_W      = DATA_W / NUM_BANKS;
  localparam int BANK_STRB_W = BANK_W / 8;
  localparam int BANK_WORDS  = 256;

  // Depth of each lane request FIFO.
  localparam int FIFO_DEPTH = 2;

  // Accepted but unanswered host requests per splitter.
  // Also sizes the response and dead-write FIFOs.
  localparam int MAX_TRANS = 2;

  // Byte offset bits inside one host word.
  localparam int ALIGN_W = $clog2(STRB_W);

  // Word index bits of one bank.
  localparam int BANK_AW = $clog2(BANK_WORDS);

  // Outstanding counter width.
  localparam int OUTS_W = $clog2(MAX_TRANS + 1);

  // One lane request: address, data, strobe, write enable.
  localparam int LANE_REQ_W = ADDR_W + BANK_W + BANK_STRB_W + 1;

endpackage

/* hw/mem_split/split_fifo.sv */
/*
 * Small fall-through FIFO.
 * A word pushed into an empty FIFO shows at data_o in the same cycle.
 */

`timescale 1ns/10ps

module split_fifo #(
  parameter int unsigned WIDTH = 8,
  parameter int unsigned DEPTH = 2
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             push_i,
  input  logic [WIDTH-1:0] data_i,
  output logic             full_o,
  input  logic             pop_i,
  output logic [WIDTH-1:0] data_o,
  output logic             empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             stored_empty;
  logic             do_push;
  logic             do_pop;
  logic             bypass;

  // Pointer step with wrap at DEPTH.
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
  endfunction

  assign stored_empty = (count_q == '0);
  assign full_o       = (count_q == CNT_W'(DEPTH));

  // Nothing stored: the input word is the head.
  assign empty_o = stored_empty && !push_i;
  assign data_o  = stored_empty ? data_i : mem[rd_ptr_q];

  // A push while full is dropped.
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // Word passes straight through, storage untouched.
  assign bypass = stored_empty && do_push && do_pop;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else if (!bypass) begin
      if (do_push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + CNT_W'(1);
      end else if (do_pop && !do_push) begin
        count_q <= count_q - CNT_W'(1);
      end
    end
  end

  // Storage array.
  always_ff @(posedge clk_i) begin
    if (do_push && !bypass) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

endmodule

/* hw/mem_split/mem_split.sv */
/*
 * Host request splitter.
 * Cuts one 64-bit request into one lane request per bank and
 * answers the host once every lane has responded, in order.
 * Write lanes with zero strobe are answered internally.
 */

`timescale 1ns/10ps

module mem_split (
  input  logic                                                     clk_i,
  input  logic                                                     rst_i,
  input  logic                                                     req_i,
  output logic                                                     gnt_o,
  input  logic [bank_pkg::ADDR_W-1:0]                              addr_i,
  input  logic [bank_pkg::DATA_W-1:0]                              wdata_i,
  input  logic [bank_pkg::STRB_W-1:0]                              strb_i,
  input  logic                                                     we_i,
  output logic                                                     rvalid_o,
  output logic [bank_pkg::DATA_W-1:0]                              rdata_o,
  output logic [bank_pkg::NUM_BANKS-1:0]                           lane_req_o,
  input  logic [bank_pkg::NUM_BANKS-1:0]                           lane_gnt_i,
  output logic [bank_pkg::NUM_BANKS-1:0][bank_pkg::ADDR_W-1:0]     lane_addr_o,
  output logic [bank_pkg::NUM_BANKS-1:0][bank_pkg::BANK_W-1:0]     lane_wdata_o,
  output logic [bank_pkg::NUM_BANKS-1:0][bank_pkg::BANK_STRB_W-1:0] lane_strb_o,
  output logic [bank_pkg::NUM_BANKS-1:0]                           lane_we_o,
  input  logic [bank_pkg::NUM_BANKS-1:0]                           lane_rvalid_i,
  input  logic [bank_pkg::NUM_BANKS-1:0][bank_pkg::BANK_W-1:0]     lane_rdata_i
);

  logic                                                      accept;
  logic [bank_pkg::ADDR_W-1:0]                               addr_base;
  logic [bank_pkg::NUM_BANKS-1:0][bank_pkg::LANE_REQ_W-1:0]  req_slice;
  logic [bank_pkg::NUM_BANKS-1:0][bank_pkg::LANE_REQ_W-1:0]  req_head;
  logic [bank_pkg::NUM_BANKS-1:0]                            req_full;
  logic [bank_pkg::NUM_BANKS-1:0]                            req_empty;
  logic [bank_pkg::NUM_BANKS-1:0]                            req_pop;
  logic [bank_pkg::NUM_BANKS-1:0]                            lane_dead;
  logic [bank_pkg::NUM_BANKS-1:0]                            resp_empty;
  logic [bank_pkg::NUM_BANKS-1:0]                            resp_pop;
  logic [bank_pkg::NUM_BANKS-1:0]                            lane_done;
  logic [bank_pkg::NUM_BANKS-1:0]                            dead_push;
  logic [bank_pkg::NUM_BANKS-1:0]                            dead_mask;
  logic                                                      dead_full;
  logic                                                      dead_empty;
  logic [bank_pkg::OUTS_W-1:0]                               outs_q;

  // Host address aligned down to a full host word.
  assign addr_base = {addr_i[bank_pkg::ADDR_W-1:bank_pkg::ALIGN_W],
                      {bank_pkg::ALIGN_W{1'b0}}};

  // Room in every lane, below the outstanding limit.
  assign gnt_o = !(|req_full) && (outs_q < bank_pkg::OUTS_W'(bank_pkg::MAX_TRANS))
                 && !dead_full;
  assign accept = req_i && gnt_o;

  for (genvar k = 0; k < bank_pkg::NUM_BANKS; k++) begin : gen_lane
    logic [bank_pkg::ADDR_W-1:0] slice_addr;

    // Each lane owns two bytes of the host word.
    assign slice_addr   = addr_base + bank_pkg::ADDR_W'(k * bank_pkg::BANK_STRB_W);
    assign req_slice[k] = {slice_addr,
                           wdata_i[k*bank_pkg::BANK_W +: bank_pkg::BANK_W],
                           strb_i[k*bank_pkg::BANK_STRB_W +: bank_pkg::BANK_STRB_W],
                           we_i};

    // Write lane with nothing to write.
    assign dead_push[k] = we_i &&
                          (strb_i[k*bank_pkg::BANK_STRB_W +: bank_pkg::BANK_STRB_W] == '0);

    split_fifo #(
      .WIDTH (bank_pkg::LANE_REQ_W),
      .DEPTH (bank_pkg::FIFO_DEPTH)
    ) u_req_fifo (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .push_i  (accept),
      .data_i  (req_slice[k]),
      .full_o  (req_full[k]),
      .pop_i   (req_pop[k]),
      .data_o  (req_head[k]),
      .empty_o (req_empty[k])
    );

    assign {lane_addr_o[k], lane_wdata_o[k], lane_strb_o[k], lane_we_o[k]} = req_head[k];

    // Dead heads are dropped here and never reach the bank.
    assign lane_dead[k]  = !req_empty[k] && lane_we_o[k] && (lane_strb_o[k] == '0);
    assign lane_req_o[k] = !req_empty[k] && !lane_dead[k];
    assign req_pop[k]    = lane_gnt_i[k] || lane_dead[k];

    split_fifo #(
      .WIDTH (bank_pkg::BANK_W),
      .DEPTH (bank_pkg::MAX_TRANS)
    ) u_resp_fifo (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .push_i  (lane_rvalid_i[k]),
      .data_i  (lane_rdata_i[k]),
      .full_o  (),
      .pop_i   (resp_pop[k]),
      .data_o  (rdata_o[k*bank_pkg::BANK_W +: bank_pkg::BANK_W]),
      .empty_o (resp_empty[k])
    );

    // Dead lanes have no stored response to drop.
    assign resp_pop[k] = rvalid_o && !dead_mask[k];
  end

  // One dead-lane mask per accepted request.
  split_fifo #(
    .WIDTH (bank_pkg::NUM_BANKS),
    .DEPTH (bank_pkg::MAX_TRANS)
  ) u_dead_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (accept),
    .data_i  (dead_push),
    .full_o  (dead_full),
    .pop_i   (rvalid_o),
    .data_o  (dead_mask),
    .empty_o (dead_empty)
  );

  // Oldest request is done once each lane has data or is dead.
  // Counter gating keeps the answer at least a cycle after acceptance.
  assign lane_done = ~resp_empty | dead_mask;
  assign rvalid_o  = (outs_q != '0) && !dead_empty && (&lane_done);

  // Accepted but unanswered requests.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      outs_q <= '0;
    end else if (accept && !rvalid_o) begin
      outs_q <= outs_q + bank_pkg::OUTS_W'(1);
    end else if (rvalid_o && !accept) begin
      outs_q <= outs_q - bank_pkg::OUTS_W'(1);
    end
  end

endmodule

/* hw/bank_arb.sv */
/*
 * Two-port round-robin bank arbiter.
 * Grants one splitter lane per cycle and routes the bank
 * response back to the port that issued it.
 */

`timescale 1ns/10ps

module bank_arb (
  input  logic                                                       clk_i,
  input  logic                                                       rst_i,
  input  logic [bank_pkg::NUM_PORTS-1:0]                             p_req_i,
  output logic [bank_pkg::NUM_PORTS-1:0]                             p_gnt_o,
  input  logic [bank_pkg::NUM_PORTS-1:0][bank_pkg::ADDR_W-1:0]       p_addr_i,
  input  logic [bank_pkg::NUM_PORTS-1:0][bank_pkg::BANK_W-1:0]       p_wdata_i,
  input  logic [bank_pkg::NUM_PORTS-1:0][bank_pkg::BANK_STRB_W-1:0]  p_strb_i,
  input  logic [bank_pkg::NUM_PORTS-1:0]                             p_we_i,
  output logic [bank_pkg::NUM_PORTS-1:0]                             p_rvalid_o,
  output logic [bank_pkg::NUM_PORTS-1:0][bank_pkg::BANK_W-1:0]       p_rdata_o,
  output logic                                                       bank_req_o,
  output logic [bank_pkg::ADDR_W-1:0]                                bank_addr_o,
  output logic [bank_pkg::BANK_W-1:0]                                bank_wdata_o,
  output logic [bank_pkg::BANK_STRB_W-1:0]                           bank_strb_o,
  output logic                                                       bank_we_o,
  input  logic                                                       bank_rvalid_i,
  input  logic [bank_pkg::BANK_W-1:0]                                bank_rdata_i
);

  logic any_req;
  logic win;
  logic last_q;

  assign any_req = |p_req_i;

  // Under contention the port not granted last time wins.
  always_comb begin
    if (&p_req_i) begin
      win = !last_q;
    end else begin
      win = p_req_i[1];
    end
  end

  for (genvar p = 0; p < bank_pkg::NUM_PORTS; p++) begin : gen_port
    assign p_gnt_o[p] = any_req && (win == 1'(p));
    // Bank answers one cycle after the grant, so last_q is still the owner.
    assign p_rvalid_o[p] = bank_rvalid_i && (last_q == 1'(p));
    assign p_rdata_o[p]  = bank_rdata_i;
  end

  // Winner's request goes to the bank.
  assign bank_req_o   = any_req;
  assign bank_addr_o  = p_addr_i[win];
  assign bank_wdata_o = p_wdata_i[win];
  assign bank_strb_o  = p_strb_i[win];
  assign bank_we_o    = p_we_i[win];

  // Last winner, also the owner of the next bank response.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      last_q <= 1'b0;
    end else if (any_req) begin
      last_q <= win;
    end
  end

endmodule

/* hw/sram_bank.sv */
/*
 * Single-port 16-bit SRAM bank.
 * Byte-writable, answers every request one cycle later.
 */

`timescale 1ns/10ps

module sram_bank (
  input  logic                             clk_i,
  input  logic                             rst_i,
  input  logic                             req_i,
  input  logic [bank_pkg::ADDR_W-1:0]      addr_i,
  input  logic [bank_pkg::BANK_W-1:0]      wdata_i,
  input  logic [bank_pkg::BANK_STRB_W-1:0] strb_i,
  input  logic                             we_i,
  output logic                             rvalid_o,
  output logic [bank_pkg::BANK_W-1:0]      rdata_o
);

  logic [bank_pkg::BANK_W-1:0]  mem [bank_pkg::BANK_WORDS];
  logic [bank_pkg::BANK_AW-1:0] idx;

  // Word index sits above the host word offset.
  assign idx = addr_i[bank_pkg::ALIGN_W +: bank_pkg::BANK_AW];

  // Read returns the old word on a same-cycle write.
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= mem[idx];
      for (int b = 0; b < bank_pkg::BANK_STRB_W; b++) begin
        if (we_i && strb_i[b]) begin
          mem[idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= req_i;
    end
  end

endmodule

/* hw/banked_mem_top.sv */
/*
 * Banked scratchpad top level.
 * Two host ports share four SRAM banks through per-bank arbiters.
 */

`timescale 1ns/10ps

module banked_mem_top (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          a_req_i,
  output logic                          a_gnt_o,
  input  logic [bank_pkg::ADDR_W-1:0]   a_addr_i,
  input  logic [bank_pkg::DATA_W-1:0]   a_wdata_i,
  input  logic [bank_pkg::STRB_W-1:0]   a_strb_i,
  input  logic                          a_we_i,
  output logic                          a_rvalid_o,
  output logic [bank_pkg::DATA_W-1:0]   a_rdata_o,
  input  logic                          b_req_i,
  output logic                          b_gnt_o,
  input  logic [bank_pkg::ADDR_W-1:0]   b_addr_i,
  input  logic [bank_pkg::DATA_W-1:0]   b_wdata_i,
  input  logic [bank_pkg::STRB_W-1:0]   b_strb_i,
  input  logic                          b_we_i,
  output logic                          b_rvalid_o,
  output logic [bank_pkg::DATA_W-1:0]   b_rdata_o
);

  // Lane signals, indexed by port then bank.
  logic [1:0][bank_pkg::NUM_BANKS-1:0]                           lane_req;
  logic [1:0][bank_pkg::NUM_BANKS-1:0]                           lane_gnt;
  logic [1:0][bank_pkg::NUM_BANKS-1:0][bank_pkg::ADDR_W-1:0]     lane_addr;
  logic [1:0][bank_pkg::NUM_BANKS-1:0][bank_pkg::BANK_W-1:0]     lane_wdata;
  logic [1:0][bank_pkg::NUM_BANKS-1:0][bank_pkg::BANK_STRB_W-1:0] lane_strb;
  logic [1:0][bank_pkg::NUM_BANKS-1:0]                           lane_we;
  logic [1:0][bank_pkg::NUM_BANKS-1:0]                           lane_rvalid;
  logic [1:0][bank_pkg::NUM_BANKS-1:0][bank_pkg::BANK_W-1:0]     lane_rdata;

  // Arbiter to bank signals, per bank.
  logic [bank_pkg::NUM_BANKS-1:0]                            bank_req;
  logic [bank_pkg::NUM_BANKS-1:0][bank_pkg::ADDR_W-1:0]      bank_addr;
  logic [bank_pkg::NUM_BANKS-1:0][bank_pkg::BANK_W-1:0]      bank_wdata;
  logic [bank_pkg::NUM_BANKS-1:0][bank_pkg::BANK_STRB_W-1:0] bank_strb;
  logic [bank_pkg::NUM_BANKS-1:0]                            bank_we;
  logic [bank_pkg::NUM_BANKS-1:0]                            bank_rvalid;
  logic [bank_pkg::NUM_BANKS-1:0][bank_pkg::BANK_W-1:0]      bank_rdata;

  mem_split u_split_a (
    .clk_i, .rst_i,
    .req_i (a_req_i), .gnt_o (a_gnt_o), .addr_i (a_addr_i), .wdata_i (a_wdata_i),
    .strb_i (a_strb_i), .we_i (a_we_i), .rvalid_o (a_rvalid_o), .rdata_o (a_rdata_o),
    .lane_req_o (lane_req[0]), .lane_gnt_i (lane_gnt[0]), .lane_addr_o (lane_addr[0]),
    .lane_wdata_o (lane_wdata[0]), .lane_strb_o (lane_strb[0]), .lane_we_o (lane_we[0]),
    .lane_rvalid_i (lane_rvalid[0]), .lane_rdata_i (lane_rdata[0])
  );

  mem_split u_split_b (
    .clk_i, .rst_i,
    .req_i (b_req_i), .gnt_o (b_gnt_o), .addr_i (b_addr_i), .wdata_i (b_wdata_i),
    .strb_i (b_strb_i), .we_i (b_we_i), .rvalid_o (b_rvalid_o), .rdata_o (b_rdata_o),
    .lane_req_o (lane_req[1]), .lane_gnt_i (lane_gnt[1]), .lane_addr_o (lane_addr[1]),
    .lane_wdata_o (lane_wdata[1]), .lane_strb_o (lane_strb[1]), .lane_we_o (lane_we[1]),
    .lane_rvalid_i (lane_rvalid[1]), .lane_rdata_i (lane_rdata[1])
  );

  for (genvar k = 0; k < bank_pkg::NUM_BANKS; k++) begin : gen_bank
    // Port 1 in the upper slot, port 0 in the lower.
    bank_arb u_arb (
      .clk_i, .rst_i,
      .p_req_i ({lane_req[1][k], lane_req[0][k]}),
      .p_gnt_o ({lane_gnt[1][k], lane_gnt[0][k]}),
      .p_addr_i ({lane_addr[1][k], lane_addr[0][k]}),
      .p_wdata_i ({lane_wdata[1][k], lane_wdata[0][k]}),
      .p_strb_i ({lane_strb[1][k], lane_strb[0][k]}),
      .p_we_i ({lane_we[1][k], lane_we[0][k]}),
      .p_rvalid_o ({lane_rvalid[1][k], lane_rvalid[0][k]}),
      .p_rdata_o ({lane_rdata[1][k], lane_rdata[0][k]}),
      .bank_req_o (bank_req[k]), .bank_addr_o (bank_addr[k]),
      .bank_wdata_o (bank_wdata[k]), .bank_strb_o (bank_strb[k]), .bank_we_o (bank_we[k]),
      .bank_rvalid_i (bank_rvalid[k]), .bank_rdata_i (bank_rdata[k])
    );

    sram_bank u_bank (
      .clk_i, .rst_i,
      .req_i (bank_req[k]), .addr_i (bank_addr[k]), .wdata_i (bank_wdata[k]),
      .strb_i (bank_strb[k]), .we_i (bank_we[k]),
      .rvalid_o (bank_rvalid[k]), .rdata_o (bank_rdata[k])
    );
  end

endmodule

/* verif/banked_mem_props.sv */
/*
 * Splitter assertions, bound into every mem_split.
 * Track host handshakes and lane issues to watch the outstanding
 * limit, the grant limit and dead write lanes.
 */

`timescale 1ns/10ps

module banked_mem_props (
  input logic                           clk_i,
  input logic                           rst_i,
  input logic                           req_i,
  input logic                           gnt_i,
  input logic [bank_pkg::STRB_W-1:0]    strb_i,
  input logic                           we_i,
  input logic                           rvalid_i,
  input logic [bank_pkg::NUM_BANKS-1:0] lane_req_i,
  input logic [bank_pkg::NUM_BANKS-1:0] lane_gnt_i
);

  logic                           accept;
  logic [bank_pkg::NUM_BANKS-1:0] live_push;
  logic [bank_pkg::NUM_BANKS-1:0] lane_issue;
  logic [bank_pkg::NUM_BANKS-1:0] over_issue;
  int                             pend_q;
  int                             live_q [bank_pkg::NUM_BANKS];

  assign accept = req_i && gnt_i;

  // Lanes that must reach a bank, and lanes handed to one.
  always_comb begin
    for (int k = 0; k < bank_pkg::NUM_BANKS; k++) begin
      live_push[k]  = accept && !(we_i &&
                      (strb_i[k*bank_pkg::BANK_STRB_W +: bank_pkg::BANK_STRB_W] == '0));
      lane_issue[k] = lane_req_i[k] && lane_gnt_i[k];
      // More lane issues than live lanes means a dead lane got out.
      over_issue[k] = lane_issue[k] && (live_q[k] == 0) && !live_push[k];
    end
  end

  // Host requests accepted and not yet answered.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pend_q <= 0;
    end else begin
      pend_q <= pend_q + int'(accept) - int'(rvalid_i);
    end
  end

  // Live lane slices accepted and not yet issued, per lane.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int k = 0; k < bank_pkg::NUM_BANKS; k++) begin
        live_q[k] <= 0;
      end
    end else begin
      for (int k = 0; k < bank_pkg::NUM_BANKS; k++) begin
        live_q[k] <= live_q[k] + int'(live_push[k]) - int'(lane_issue[k]);
      end
    end
  end

  a_rvalid_outs: assert property (@(posedge clk_i) disable iff (rst_i)
    rvalid_i |-> (pend_q != 0))
    else $error("Host rvalid with no outstanding request");

  a_outs_limit: assert property (@(posedge clk_i) disable iff (rst_i)
    pend_q <= bank_pkg::MAX_TRANS)
    else $error("Outstanding count above the limit");

  a_gnt_limit: assert property (@(posedge clk_i) disable iff (rst_i)
    (pend_q == bank_pkg::MAX_TRANS) |-> !gnt_i)
    else $error("Grant high at the outstanding limit");

  a_no_dead_req: assert property (@(posedge clk_i) disable iff (rst_i)
    over_issue == '0)
    else $error("Lane request raised for a zero-strobe write lane");

endmodule

bind mem_split banked_mem_props u_props (
  .clk_i      (clk_i),
  .rst_i      (rst_i),
  .req_i      (req_i),
  .gnt_i      (gnt_o),
  .strb_i     (strb_i),
  .we_i       (we_i),
  .rvalid_i   (rvalid_o),
  .lane_req_i (lane_req_o),
  .lane_gnt_i (lane_gnt_i)
);

/* verif/banked_mem_checker.sv */
/*
 * Response checker for both host ports.
 * Keeps a byte-wise model memory and an expected-response queue per port.
 */

`timescale 1ns/10ps

module banked_mem_checker (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        a_req_i,
  input  logic                        a_gnt_i,
  input  logic [bank_pkg::ADDR_W-1:0] a_addr_i,
  input  logic [bank_pkg::DATA_W-1:0] a_wdata_i,
  input  logic [bank_pkg::STRB_W-1:0] a_strb_i,
  input  logic                        a_we_i,
  input  logic                        a_rvalid_i,
  input  logic [bank_pkg::DATA_W-1:0] a_rdata_i,
  input  logic                        b_req_i,
  input  logic                        b_gnt_i,
  input  logic [bank_pkg::ADDR_W-1:0] b_addr_i,
  input  logic [bank_pkg::DATA_W-1:0] b_wdata_i,
  input  logic [bank_pkg::STRB_W-1:0] b_strb_i,
  input  logic                        b_we_i,
  input  logic                        b_rvalid_i,
  input  logic [bank_pkg::DATA_W-1:0] b_rdata_i,
  output int                          error_count_o,
  output int                          resp_count_o
);

  // Model of the whole byte address space.
  logic [7:0] model_mem [1 << bank_pkg::ADDR_W];

  // Entry is {is_read, expected word}, write entries are markers.
  logic [bank_pkg::DATA_W:0] exp_a [$];
  logic [bank_pkg::DATA_W:0] exp_b [$];

  logic rst_q = 1'b1;
  int   errors = 0;
  int   responses = 0;

  assign error_count_o = errors;
  assign resp_count_o  = responses;

  // Applies an accepted request to the model and queues its answer.
  task automatic record_request(input int port, input logic [bank_pkg::ADDR_W-1:0] addr,
                                input logic [bank_pkg::DATA_W-1:0] wdata,
                                input logic [bank_pkg::STRB_W-1:0] strb, input logic we);
    logic [bank_pkg::ADDR_W-1:0] byte_addr;
    logic [bank_pkg::DATA_W:0]   entry;
    entry = '0;
    for (int b = 0; b < bank_pkg::STRB_W; b++) begin
      byte_addr = {addr[bank_pkg::ADDR_W-1:bank_pkg::ALIGN_W], bank_pkg::ALIGN_W'(b)};
      if (!we) begin
        entry[b*8 +: 8] = model_mem[byte_addr];
      end else if (strb[b]) begin
        model_mem[byte_addr] = wdata[b*8 +: 8];
      end
    end
    entry[bank_pkg::DATA_W] = !we;
    if (port == 0) begin
      exp_a.push_back(entry);
    end else begin
      exp_b.push_back(entry);
    end
  endtask

  // Matches one host response against the oldest queued entry.
  task automatic check_response(input int port, input logic [bank_pkg::DATA_W-1:0] rdata);
    logic [bank_pkg::DATA_W:0] entry;
    string                     name;
    name = (port == 0) ? "port_a_read" : "port_b_read";
    if ((port == 0) ? (exp_a.size() == 0) : (exp_b.size() == 0)) begin
      $display("Port %0d answered with no request outstanding", port);
      errors = errors + 1;
    end else begin
      if (port == 0) begin
        entry = exp_a.pop_front();
      end else begin
        entry = exp_b.pop_front();
      end
      responses = responses + 1;
      // Write responses carry no data to compare.
      if (entry[bank_pkg::DATA_W] && (rdata !== entry[bank_pkg::DATA_W-1:0])) begin
        $display("ERROR %s: expected %h actual %h", name,
                 entry[bank_pkg::DATA_W-1:0], rdata);
        errors = errors + 1;
      end
    end
  endtask

  always @(posedge clk_i) begin
    rst_q <= rst_i;
    if (!rst_i) begin
      // First cycle out of reset.
      if (rst_q && (!a_gnt_i || a_rvalid_i || !b_gnt_i || b_rvalid_i)) begin
        $display("Wrong state after reset, gnt must be high and rvalid low");
        errors = errors + 1;
      end
      // Responses belong to earlier requests, so they go first.
      if (a_rvalid_i) begin
        check_response(0, a_rdata_i);
      end
      if (b_rvalid_i) begin
        check_response(1, b_rdata_i);
      end
      if (a_req_i && a_gnt_i) begin
        record_request(0, a_addr_i, a_wdata_i, a_strb_i, a_we_i);
      end
      if (b_req_i && b_gnt_i) begin
        record_request(1, b_addr_i, b_wdata_i, b_strb_i, b_we_i);
      end
      if ((exp_a.size() > bank_pkg::MAX_TRANS) || (exp_b.size() > bank_pkg::MAX_TRANS)) begin
        $display("More than %0d requests outstanding on one port", bank_pkg::MAX_TRANS);
        errors = errors + 1;
      end
    end
  end

endmodule

/* verif/banked_mem_tb.sv */
/*
 * Testbench for the banked scratchpad.
 * Random LFSR traffic on both host ports, checked by a separate checker.
 */

`timescale 1ns/10ps

module banked_mem_tb;

  localparam int NUM_REQ    = 400;
  localparam int PREFILL    = 16;
  localparam int TOTAL_RESP = NUM_REQ * bank_pkg::NUM_PORTS;
  localparam int TIMEOUT_CYCLES =
    NUM_REQ * (1 + bank_pkg::MAX_TRANS) * bank_pkg::NUM_PORTS + 200;
  localparam int REQ_W = 1 + bank_pkg::STRB_W + bank_pkg::DATA_W + bank_pkg::ADDR_W;

  logic                        clk_i = 1'b0;
  logic                        rst_i;
  logic                        a_req, a_gnt, a_we, a_rvalid;
  logic [bank_pkg::ADDR_W-1:0] a_addr;
  logic [bank_pkg::DATA_W-1:0] a_wdata, a_rdata;
  logic [bank_pkg::STRB_W-1:0] a_strb;
  logic                        b_req, b_gnt, b_we, b_rvalid;
  logic [bank_pkg::ADDR_W-1:0] b_addr;
  logic [bank_pkg::DATA_W-1:0] b_wdata, b_rdata;
  logic [bank_pkg::STRB_W-1:0] b_strb;
  logic [31:0]                 lfsr_q = 32'h8b79_3166;
  int                          a_sent = 0;
  int                          b_sent = 0;
  int                          cycle_count;
  int                          error_count;
  int                          resp_count;

  banked_mem_top DUT (
    .clk_i, .rst_i,
    .a_req_i (a_req), .a_gnt_o (a_gnt), .a_addr_i (a_addr), .a_wdata_i (a_wdata),
    .a_strb_i (a_strb), .a_we_i (a_we), .a_rvalid_o (a_rvalid), .a_rdata_o (a_rdata),
    .b_req_i (b_req), .b_gnt_o (b_gnt), .b_addr_i (b_addr), .b_wdata_i (b_wdata),
    .b_strb_i (b_strb), .b_we_i (b_we), .b_rvalid_o (b_rvalid), .b_rdata_o (b_rdata)
  );

  banked_mem_checker u_checker (
    .clk_i, .rst_i,
    .a_req_i (a_req), .a_gnt_i (a_gnt), .a_addr_i (a_addr), .a_wdata_i (a_wdata),
    .a_strb_i (a_strb), .a_we_i (a_we), .a_rvalid_i (a_rvalid), .a_rdata_i (a_rdata),
    .b_req_i (b_req), .b_gnt_i (b_gnt), .b_addr_i (b_addr), .b_wdata_i (b_wdata),
    .b_strb_i (b_strb), .b_we_i (b_we), .b_rvalid_i (b_rvalid), .b_rdata_i (b_rdata),
    .error_count_o (error_count), .resp_count_o (resp_count)
  );

  always #2 clk_i = ~clk_i;

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit.
  function automatic logic rand_bit();
    lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
    return lfsr_q[0];
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], rand_bit()};
    end
    return v;
  endfunction

  // Packs {we, strb, wdata, addr}. The first PREFILL requests write whole words.
  function automatic logic [REQ_W-1:0] build_request(input int idx, input logic hi_bit);
    logic [63:0] r;
    logic [3:0]  word;
    logic [2:0]  off;
    logic        we;
    logic [7:0]  strb;
    logic [63:0] wdata;
    wdata = rand_bits(64);
    r = rand_bits(3);
    off = r[2:0];
    if (idx < PREFILL) begin
      we   = 1'b1;
      strb = 8'hff;
      word = 4'(idx);
    end else begin
      we = rand_bit();
      r = rand_bits(8);
      strb = r[7:0];
      r = rand_bits(4);
      word = r[3:0];
    end
    // Bit 10 is the top index bit and splits the ports.
    return {we, strb, wdata, 5'b0, hi_bit, 3'b0, word, off};
  endfunction

  // Each port holds its request until granted.
  always @(posedge clk_i) begin
    if (!rst_i) begin
      if (a_req && a_gnt) begin
        a_sent = a_sent + 1;
      end
      if (!a_req || a_gnt) begin
        if (a_sent < NUM_REQ && rand_bit()) begin
          a_req <= 1'b1;
          {a_we, a_strb, a_wdata, a_addr} <= build_request(a_sent, 1'b0);
        end else begin
          a_req <= 1'b0;
        end
      end
      if (b_req && b_gnt) begin
        b_sent = b_sent + 1;
      end
      if (!b_req || b_gnt) begin
        if (b_sent < NUM_REQ && rand_bit()) begin
          b_req <= 1'b1;
          {b_we, b_strb, b_wdata, b_addr} <= build_request(b_sent, 1'b1);
        end else begin
          b_req <= 1'b0;
        end
      end
    end
  end

  always @(posedge clk_i) begin
    if (rst_i) begin
      cycle_count <= 0;
    end else begin
      cycle_count <= cycle_count + 1;
    end
  end

  initial begin
    rst_i   <= 1'b1;
    a_req   <= 1'b0;
    a_we    <= 1'b0;
    a_addr  <= '0;
    a_wdata <= '0;
    a_strb  <= '0;
    b_req   <= 1'b0;
    b_we    <= 1'b0;
    b_addr  <= '0;
    b_wdata <= '0;
    b_strb  <= '0;
    repeat (16) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    // Counters are read away from the rising edge.
    while (resp_count < TOTAL_RESP && cycle_count < TIMEOUT_CYCLES) begin
      @(negedge clk_i);
    end
    if (resp_count < TOTAL_RESP) begin
      $display("Timeout after %0d cycles, only %0d of %0d responses arrived",
               cycle_count, resp_count, TOTAL_RESP);
    end
    $display("Done with %0d errors and %0d responses", error_count, resp_count);
    if (error_count == 0 && resp_count == TOTAL_RESP) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* banked_mem.f */
common/bank_pkg.sv
hw/mem_split/split_fifo.sv
hw/mem_split/mem_split.sv
hw/bank_arb.sv
hw/sram_bank.sv
hw/banked_mem_top.sv
verif/banked_mem_props.sv
verif/banked_mem_checker.sv
verif/banked_mem_tb.sv

/* Makefile */
# Verilator lint and simulation for the banked scratchpad.

VERILATOR := verilator
FLAGS     := --timing --assert --timescale 1ns/10ps
SIM_FLAGS := --binary
TOP       := banked_mem_tb
FILELIST  := banked_mem.f
OBJ_DIR   := obj_dir
PASS_MSG  := NO ERRORS

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# The run passes only if the pass message shows up as a line of its own.
sim:
	$(VERILATOR) $(SIM_FLAGS) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
